/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  memaddr_t;     // Word index, not byte address
    typedef logic [3:0]  reg_idx_t;

    localparam int    IMEM_DEPTH     = 256;
    localparam int    NUM_REGS       = 16;
    localparam string IMEM_INIT_FILE = "tests/program.hex";

    // Opcodes 6 to 15 are illegal
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        ADDI = 4'd4,
        LUI  = 4'd5
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_e;

    // Register form
    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    rd;
        reg_idx_t    ra;
        reg_idx_t    rb;
        logic [15:0] unused;
    } r_fmt_t;

    // Immediate form
    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    rd;
        reg_idx_t    ra;
        logic [19:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     use_imm;      // op2 from immediate
        logic     zero_op1;     // LUI and illegal
        logic     has_rd;
        reg_idx_t rd;
        reg_idx_t ra;
        reg_idx_t rb;
        logic     illegal;
    } control_word_t;

    typedef struct packed {
        word_t  pc;
        instr_u ir;
    } fetch_t;

    typedef struct packed {
        word_t         pc;
        control_word_t cw;
        word_t         imm;
    } decode_t;

    typedef struct packed {
        word_t         pc;
        control_word_t cw;
        word_t         alu_op1;
        word_t         alu_op2;
    } issue_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

`default_nettype wire

/* hw/instruction_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_memory (
    input  wire logic              cpu_clk_i,
    input  wire logic              reset_i,
    input  wire logic              req_valid_i,
    input  wire cpu_pkg::memaddr_t req_addr_i,
    output logic                   resp_valid_o,
    output cpu_pkg::word_t         resp_data_o
);
    import cpu_pkg::*;

    word_t rom [IMEM_DEPTH];

    initial begin
        $readmemh(IMEM_INIT_FILE, rom);
    end

    // One-cycle read, data only moves on a request
    always_ff @(posedge cpu_clk_i) begin
        if (req_valid_i) begin
            resp_data_o <= rom[req_addr_i];
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (reset_i) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= req_valid_i;    // Always accepted
        end
    end

endmodule

`default_nettype wire

/* hw/stage_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_fetch (
    input  wire logic              cpu_clk_i,
    input  wire logic              reset_i,
    input  wire logic              halt_i,
    output logic                   imem_req_valid_o,
    output cpu_pkg::memaddr_t      imem_req_addr_o,
    input  wire logic              imem_resp_valid_i,
    input  wire cpu_pkg::word_t    imem_resp_data_i,
    output cpu_pkg::fetch_t        fetch_o,
    output logic                   fetch_valid_o,
    input  wire logic              fetch_ready_i
);
    import cpu_pkg::*;

    memaddr_t req_idx_r;        // Next word to request
    memaddr_t inflight_idx_r;   // Word sitting in memory
    fetch_t   out_r;
    logic     out_valid_r;
    logic     run_r;            // Low for the first cycle out of reset
    logic     occupied_next;

    // Register still holds a word next cycle, so a new response could not land
    assign occupied_next = imem_resp_valid_i || (out_valid_r && !fetch_ready_i);

    assign imem_req_valid_o = run_r && !halt_i && !occupied_next;
    assign imem_req_addr_o  = req_idx_r;
    assign fetch_o          = out_r;
    assign fetch_valid_o    = out_valid_r;

    always_ff @(posedge cpu_clk_i) begin
        if (reset_i) begin
            run_r       <= 1'b0;
            req_idx_r   <= '0;
            out_valid_r <= 1'b0;
        end else begin
            run_r <= 1'b1;
            if (imem_req_valid_o) begin
                req_idx_r <= req_idx_r + memaddr_t'(1);   // Wraps at end of ROM
            end
            if (imem_resp_valid_i) begin
                out_valid_r <= 1'b1;
            end else if (fetch_ready_i) begin
                out_valid_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (imem_req_valid_o) begin
            inflight_idx_r <= req_idx_r;
        end
        if (imem_resp_valid_i) begin
            out_r.pc <= {22'b0, inflight_idx_r, 2'b00};   // Byte address
            out_r.ir <= imem_resp_data_i;
        end
    end

    a_resp_has_room: assert property (@(posedge cpu_clk_i) disable iff (reset_i)
        imem_resp_valid_i |-> (!out_valid_r || fetch_ready_i))
        else $error("fetch: memory response arrived while output register was stalled");

endmodule

`default_nettype wire

/* hw/stage_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_decode (
    input  wire logic            cpu_clk_i,
    input  wire logic            reset_i,
    input  wire cpu_pkg::fetch_t fetch_i,
    input  wire logic            fetch_valid_i,
    output logic                 fetch_ready_o,
    output cpu_pkg::decode_t     decode_o,
    output logic                 decode_valid_o,
    input  wire logic            decode_ready_i
);
    import cpu_pkg::*;

    instr_u  ir;
    decode_t dec;
    decode_t dec_r;
    logic    valid_r;

    assign ir = fetch_i.ir;

    always_comb begin
        dec.pc          = fetch_i.pc;
        dec.cw.alu_op   = ALU_ADD;
        dec.cw.use_imm  = 1'b0;
        dec.cw.zero_op1 = 1'b0;
        dec.cw.has_rd   = (ir.r_fmt.rd != '0);    // r0 is never written
        dec.cw.rd       = ir.r_fmt.rd;
        dec.cw.ra       = ir.r_fmt.ra;
        dec.cw.rb       = ir.r_fmt.rb;
        dec.cw.illegal  = 1'b0;
        dec.imm         = '0;
        case (ir.r_fmt.opcode)
            ADD: dec.cw.alu_op = ALU_ADD;
            SUB: dec.cw.alu_op = ALU_SUB;
            AND: dec.cw.alu_op = ALU_AND;
            OR:  dec.cw.alu_op = ALU_OR;
            ADDI: begin
                dec.cw.use_imm = 1'b1;
                dec.imm        = {{12{ir.i_fmt.imm[19]}}, ir.i_fmt.imm};
            end
            LUI: begin
                dec.cw.use_imm  = 1'b1;
                dec.cw.zero_op1 = 1'b1;
                dec.imm         = {ir.i_fmt.imm, 12'b0};
            end
            default: begin
                // Both operands come out zero and no sources are read
                dec.cw.illegal  = 1'b1;
                dec.cw.has_rd   = 1'b0;
                dec.cw.use_imm  = 1'b1;
                dec.cw.zero_op1 = 1'b1;
            end
        endcase
    end

    assign fetch_ready_o  = !valid_r || decode_ready_i;
    assign decode_o       = dec_r;
    assign decode_valid_o = valid_r;

    always_ff @(posedge cpu_clk_i) begin
        if (reset_i) begin
            valid_r <= 1'b0;
        end else if (fetch_ready_o) begin
            valid_r <= fetch_valid_i;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (fetch_valid_i && fetch_ready_o) begin
            dec_r <= dec;
        end
    end

endmodule

`default_nettype wire

/* hw/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic              cpu_clk_i,
    input  wire logic              reset_i,
    input  wire cpu_pkg::reg_idx_t rd_idx_a_i,
    input  wire cpu_pkg::reg_idx_t rd_idx_b_i,
    output cpu_pkg::word_t         rd_data_a_o,
    output cpu_pkg::word_t         rd_data_b_o,
    input  wire cpu_pkg::wb_t      wb_i
);
    import cpu_pkg::*;

    word_t regs [NUM_REGS];

    // Same-cycle writeback wins over the stored value
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_i.valid && wb_i.rd == idx) begin
            return wb_i.data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rd_data_a_o = read_port(rd_idx_a_i);
        rd_data_b_o = read_port(rd_idx_b_i);
    end

    always_ff @(posedge cpu_clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

endmodule

`default_nettype wire

/* hw/stage_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_issue (
    input  wire logic              cpu_clk_i,
    input  wire logic              reset_i,
    input  wire cpu_pkg::decode_t  decode_i,
    input  wire logic              decode_valid_i,
    output logic                   decode_ready_o,
    output cpu_pkg::reg_idx_t      rf_idx_a_o,
    output cpu_pkg::reg_idx_t      rf_idx_b_o,
    input  wire cpu_pkg::word_t    rf_data_a_i,
    input  wire cpu_pkg::word_t    rf_data_b_i,
    input  wire cpu_pkg::wb_t      wb_i,
    output cpu_pkg::issue_t        issue_o,
    output logic                   issue_valid_o,
    input  wire logic              issue_ready_i
);
    import cpu_pkg::*;

    control_word_t       cw;
    logic [NUM_REGS-1:0] busy_r;        // Awaiting writeback
    logic [NUM_REGS-1:0] busy_now;
    logic [NUM_REGS-1:0] wb_mask;
    logic [NUM_REGS-1:0] set_mask;
    logic                use_a;
    logic                use_b;
    logic                hazard;
    logic                out_free;
    logic                take;
    word_t               op1;
    word_t               op2;
    issue_t              out_r;
    logic                out_valid_r;

    assign cw    = decode_i.cw;
    assign use_a = !cw.zero_op1;
    assign use_b = !cw.use_imm;

    always_comb begin
        wb_mask  = '0;
        set_mask = '0;
        if (wb_i.valid) begin
            wb_mask[wb_i.rd] = 1'b1;
        end
        if (take && cw.has_rd) begin
            set_mask[cw.rd] = 1'b1;
        end
    end

    // A writeback this cycle already counts as done
    assign busy_now = busy_r & ~wb_mask;

    // RAW on either source, WAW on rd
    assign hazard = (use_a && busy_now[cw.ra])
                 || (use_b && busy_now[cw.rb])
                 || (cw.has_rd && busy_now[cw.rd]);

    assign out_free       = !out_valid_r || issue_ready_i;
    assign decode_ready_o = out_free && !hazard;
    assign take           = decode_valid_i && decode_ready_o;

    assign rf_idx_a_o = cw.ra;
    assign rf_idx_b_o = cw.rb;
    assign op1        = cw.zero_op1 ? '0 : rf_data_a_i;   // Bypass lives in the register file
    assign op2        = cw.use_imm ? decode_i.imm : rf_data_b_i;

    assign issue_o       = out_r;
    assign issue_valid_o = out_valid_r;

    always_ff @(posedge cpu_clk_i) begin
        if (reset_i) begin
            busy_r      <= '0;
            out_valid_r <= 1'b0;
        end else begin
            busy_r <= busy_now | set_mask;
            if (out_free) begin
                out_valid_r <= take;
            end
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (take) begin
            out_r.pc      <= decode_i.pc;
            out_r.cw      <= cw;
            out_r.alu_op1 <= op1;
            out_r.alu_op2 <= op2;
        end
    end

    a_hold_under_stall: assert property (@(posedge cpu_clk_i) disable iff (reset_i)
        (issue_valid_o && !issue_ready_i) |=> (issue_valid_o && $stable(issue_o)))
        else $error("issue: output changed while stalled");

    a_wb_to_busy: assert property (@(posedge cpu_clk_i) disable iff (reset_i)
        wb_i.valid |-> busy_r[wb_i.rd])
        else $error("issue: writeback to r%0d which is not awaiting a result", wb_i.rd);

endmodule

`default_nettype wire

/* hw/frontend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_top (
    input  wire logic            cpu_clk_i,
    input  wire logic            reset_i,
    input  wire logic            halt_i,
    output cpu_pkg::issue_t      issue_o,
    output logic                 issue_valid_o,
    input  wire logic            issue_ready_i,
    input  wire cpu_pkg::wb_t    wb_i
);
    import cpu_pkg::*;

    memaddr_t imem_req_addr;
    logic     imem_req_valid;
    logic     imem_resp_valid;
    word_t    imem_resp_data;
    fetch_t   fetch;
    logic     fetch_valid;
    logic     fetch_ready;
    decode_t  decode;
    logic     decode_valid;
    logic     decode_ready;
    reg_idx_t rf_idx_a;
    reg_idx_t rf_idx_b;
    word_t    rf_data_a;
    word_t    rf_data_b;

    instruction_memory imem (
        .cpu_clk_i    (cpu_clk_i),
        .reset_i      (reset_i),
        .req_valid_i  (imem_req_valid),
        .req_addr_i   (imem_req_addr),
        .resp_valid_o (imem_resp_valid),
        .resp_data_o  (imem_resp_data)
    );

    stage_fetch stage_fetch (
        .cpu_clk_i         (cpu_clk_i),
        .reset_i           (reset_i),
        .halt_i            (halt_i),
        .imem_req_valid_o  (imem_req_valid),
        .imem_req_addr_o   (imem_req_addr),
        .imem_resp_valid_i (imem_resp_valid),
        .imem_resp_data_i  (imem_resp_data),
        .fetch_o           (fetch),
        .fetch_valid_o     (fetch_valid),
        .fetch_ready_i     (fetch_ready)
    );

    stage_decode stage_decode (
        .cpu_clk_i      (cpu_clk_i),
        .reset_i        (reset_i),
        .fetch_i        (fetch),
        .fetch_valid_i  (fetch_valid),
        .fetch_ready_o  (fetch_ready),
        .decode_o       (decode),
        .decode_valid_o (decode_valid),
        .decode_ready_i (decode_ready)
    );

    stage_issue stage_issue (
        .cpu_clk_i      (cpu_clk_i),
        .reset_i        (reset_i),
        .decode_i       (decode),
        .decode_valid_i (decode_valid),
        .decode_ready_o (decode_ready),
        .rf_idx_a_o     (rf_idx_a),
        .rf_idx_b_o     (rf_idx_b),
        .rf_data_a_i    (rf_data_a),
        .rf_data_b_i    (rf_data_b),
        .wb_i           (wb_i),
        .issue_o        (issue_o),
        .issue_valid_o  (issue_valid_o),
        .issue_ready_i  (issue_ready_i)
    );

    // Writeback from execute goes straight to the write port
    register_file register_file (
        .cpu_clk_i   (cpu_clk_i),
        .reset_i     (reset_i),
        .rd_idx_a_i  (rf_idx_a),
        .rd_idx_b_i  (rf_idx_b),
        .rd_data_a_o (rf_data_a),
        .rd_data_b_o (rf_data_b),
        .wb_i        (wb_i)
    );

endmodule

`default_nettype wire

/* tests/tb_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_frontend;
    import cpu_pkg::*;

    localparam int PROG_WORDS = 22;     // Words in program.hex
    localparam int HALT_AT    = 10;

    typedef struct packed {
        reg_idx_t    rd;
        word_t       data;
        logic [31:0] due;               // Cycle the result goes back
    } wb_entry_t;

    logic   cpu_clk_i;
    logic   reset_i;
    logic   halt_i;
    issue_t issue_o;
    logic   issue_valid_o;
    logic   issue_ready_i;
    wb_t    wb_i;

    word_t       prog [IMEM_DEPTH];
    word_t       model_regs [NUM_REGS];
    wb_entry_t   wbq [$];
    logic [31:0] cycle = '0;
    int          issued = 0;
    int          outstanding = 0;
    int          halt_base = 0;
    logic        checking = 1'b0;
    logic        halt_settled = 1'b0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err_base = 0;
    string       test_name;

    // Expected view of the word at exp_pc
    word_t    exp_pc;
    word_t    exp_op1;
    word_t    exp_op2;
    alu_op_e  exp_alu;
    logic     exp_has_rd;
    reg_idx_t exp_rd;
    logic     exp_illegal;

    frontend_top uut (
        .cpu_clk_i     (cpu_clk_i),
        .reset_i       (reset_i),
        .halt_i        (halt_i),
        .issue_o       (issue_o),
        .issue_valid_o (issue_valid_o),
        .issue_ready_i (issue_ready_i),
        .wb_i          (wb_i)
    );

    initial begin
        cpu_clk_i = 1'b0;
        forever #4 cpu_clk_i = ~cpu_clk_i;
    end

    function automatic word_t alu_result(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            default: return a + b;
        endcase
    endfunction

    // Sequential semantics straight from the instruction format
    task automatic set_expected();
        word_t      instr;
        logic [3:0] op;
        word_t      va;
        word_t      vb;
        instr       = prog[exp_pc[9:2]];
        op          = instr[31:28];
        exp_rd      = instr[27:24];
        va          = model_regs[instr[23:20]];
        vb          = model_regs[instr[19:16]];
        exp_illegal = (op > 4'd5);
        exp_has_rd  = !exp_illegal && (exp_rd != '0);
        exp_alu     = ALU_ADD;
        exp_op1     = va;
        exp_op2     = vb;
        case (op)
            4'd0: exp_alu = ALU_ADD;
            4'd1: exp_alu = ALU_SUB;
            4'd2: exp_alu = ALU_AND;
            4'd3: exp_alu = ALU_OR;
            4'd4: exp_op2 = {{12{instr[19]}}, instr[19:0]};
            4'd5: begin
                exp_op1 = '0;
                exp_op2 = {instr[19:0], 12'h000};
            end
            default: begin
                exp_op1 = '0;
                exp_op2 = '0;
            end
        endcase
    endtask

    // Execute stage stand-in that sees the same values as the assertions
    always @(posedge cpu_clk_i) begin : monitor
        wb_entry_t entry;
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                model_regs[i] = '0;
            end
            wbq.delete();
            exp_pc      = '0;
            issued      = 0;
            outstanding = 0;
            checking    = 1'b1;
            set_expected();
        end else begin
            if (wb_i.valid) begin
                outstanding--;
            end
            if (checking && issue_valid_o && issue_ready_i) begin
                if (exp_has_rd) begin
                    entry.rd   = exp_rd;
                    entry.data = alu_result(exp_alu, exp_op1, exp_op2);
                    entry.due  = cycle + $urandom_range(1, 4);
                    model_regs[exp_rd] = entry.data;
                    wbq.push_back(entry);
                    outstanding++;
                end
                issued++;
                exp_pc = exp_pc + 32'd4;
                if (issued == PROG_WORDS) begin
                    checking = 1'b0;
                end else begin
                    set_expected();
                end
            end
        end
        cycle = cycle + 1;
    end

    always @(negedge cpu_clk_i) begin
        issue_ready_i <= checking ? ($urandom_range(0, 99) < 70) : 1'b1;
    end

    // Results go back in order and at most one per cycle
    always @(negedge cpu_clk_i) begin
        wb_i = '0;
        if (wbq.size() > 0 && wbq[0].due <= cycle) begin
            wb_i.valid = 1'b1;
            wb_i.rd    = wbq[0].rd;
            wb_i.data  = wbq[0].data;
            void'(wbq.pop_front());
        end
    end

    a_reset_quiet: assert property (@(posedge cpu_clk_i) reset_i |=> !issue_valid_o)
        else begin
            errors++;
            $display("ERROR at %0t: issue_valid_o high straight after reset", $time);
        end

    a_pc_order: assert property (@(posedge cpu_clk_i) disable iff (reset_i)
        (issue_valid_o && checking) |-> issue_o.pc == exp_pc)
        else begin
            errors++;
            $display("MISMATCH at %0t: issued pc %h, expected %h", $time,
                     $sampled(issue_o.pc), $sampled(exp_pc));
        end

    a_operands: assert property (@(posedge cpu_clk_i) disable iff (reset_i)
        (issue_valid_o && checking) |->
            (issue_o.alu_op1 == exp_op1 && issue_o.alu_op2 == exp_op2))
        else begin
            errors++;
            $display("MISMATCH at %0t: pc %h operands %h %h, expected %h %h", $time,
                     $sampled(issue_o.pc), $sampled(issue_o.alu_op1),
                     $sampled(issue_o.alu_op2), $sampled(exp_op1), $sampled(exp_op2));
        end

    a_control: assert property (@(posedge cpu_clk_i) disable iff (reset_i)
        (issue_valid_o && checking) |->
            (issue_o.cw.illegal == exp_illegal && issue_o.cw.has_rd == exp_has_rd
             && (!exp_has_rd || issue_o.cw.rd == exp_rd)
             && (exp_illegal || issue_o.cw.alu_op == exp_alu)))
        else begin
            errors++;
            $display("MISMATCH at %0t: pc %h control word %h does not match instruction",
                     $time, $sampled(issue_o.pc), $sampled(issue_o.cw));
        end

    a_hold_stalled: assert property (@(posedge cpu_clk_i) disable iff (reset_i)
        (issue_valid_o && !issue_ready_i && checking) |=> (issue_valid_o && $stable(issue_o)))
        else begin
            errors++;
            $display("MISMATCH at %0t: issue output changed while stalled", $time);
        end

    a_halt_bound: assert property (@(posedge cpu_clk_i) disable iff (reset_i)
        (halt_i && issue_valid_o && issue_ready_i && checking) |-> (issued - halt_base) < 4)
        else begin
            errors++;
            $display("ERROR at %0t: more than four instructions issued after halt", $time);
        end

    a_halt_quiet: assert property (@(posedge cpu_clk_i) disable iff (reset_i)
        (halt_i && halt_settled) |-> !issue_valid_o)
        else begin
            errors++;
            $display("ERROR at %0t: instruction issued while halted and drained", $time);
        end

    task automatic stall_abort(input string what);
        $display("ERROR at %0t: timed out %s", $time, what);
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed + 1,
                 errors);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic wait_issued(input int target, input int limit);
        int waited;
        waited = 0;
        while (issued < target) begin
            if (waited == limit) begin
                stall_abort($sformatf("waiting for issue of %0d instructions", target));
            end
            @(negedge cpu_clk_i);
            waited++;
        end
    endtask

    // Quiet means nothing offered and no result owed
    task automatic wait_drained(input int limit);
        int waited;
        int quiet;
        waited = 0;
        quiet  = 0;
        while (quiet < 8) begin
            if (waited == limit) begin
                stall_abort("waiting for the pipeline to drain under halt");
            end
            @(negedge cpu_clk_i);
            waited++;
            quiet = (!issue_valid_o && outstanding == 0) ? quiet + 1 : 0;
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        if (errors == test_err_base) begin
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, errors - test_err_base);
        end
    endtask

    initial begin
        void'($urandom(62));
        reset_i       = 1'b1;
        halt_i        = 1'b0;
        issue_ready_i = 1'b0;
        wb_i          = '0;
        $readmemh(IMEM_INIT_FILE, prog);
        repeat (2) @(negedge cpu_clk_i);
        reset_i = 1'b0;

        start_test("reset_idle");
        wait_issued(1, 100);
        finish_test();

        start_test("in_order_issue");   // Hazards, immediates and the illegal word
        wait_issued(HALT_AT, 400);
        finish_test();

        start_test("halt_drain");
        halt_base = issued;
        halt_i    = 1'b1;
        wait_drained(300);
        halt_settled = 1'b1;
        repeat (10) @(negedge cpu_clk_i);
        finish_test();

        start_test("halt_resume");
        halt_settled = 1'b0;
        halt_i       = 1'b0;
        wait_issued(issued + 1, 100);
        finish_test();

        start_test("program_complete");
        wait_issued(PROG_WORDS, 600);
        halt_i = 1'b1;                  // Fetch would otherwise run on past the program
        wait_drained(100);
        finish_test();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hw/cpu_pkg.sv
hw/instruction_memory.sv
hw/stage_fetch.sv
hw/stage_decode.sv
hw/register_file.sv
hw/stage_issue.sv
hw/frontend_top.sv
tests/tb_frontend.sv

/* tests/program.hex */
// One 32-bit instruction per line, word address 0 upward
// Fields: opcode[31:28] rd[27:24] ra[23:20] then rb[19:16] or imm[19:0]
51012345
41100678
420FFFFF
03120000
14310000
25410000
36520000
43300010
43380000
97120000
07330000
580FFFFF
39870000
00990000
1A090000
4AA00001
2BA60000
4CB7FFFF
1DCA0000
3EDC0000
0FEF0000
4FF00005
